/* apb_bank_decode.sv */
/* APB bank decoder
 * Qualifies psel per 4 KB bank and merges the device read data into one response
 */
`timescale 1ns/1ps

module apb_bank_decode (
   input  apb_pkg::apb_req_t           apb_req,
   output apb_pkg::apb_rsp_t           apb_rsp,

   output apb_pkg::apb_req_t           gpio_req,
   output apb_pkg::apb_req_t           intc_req,
   output apb_pkg::apb_req_t           pctr_req,

   input  logic [apb_pkg::data_w-1:0]  gpio_rdata,
   input  logic [apb_pkg::data_w-1:0]  intc_rdata,
   input  logic [apb_pkg::data_w-1:0]  pctr_rdata
);

   logic [$clog2(periph_map_pkg::nr_banks)-1:0] bank;
   logic                                        access;

   assign bank   = apb_req.paddr[periph_map_pkg::bank_lsb +: $clog2(periph_map_pkg::nr_banks)];
   assign access = apb_req.psel && apb_req.penable;

   ////////////////////////////////////////////////////////////////////////////
   // Request fan-out

   always_comb begin
      gpio_req      = apb_req;
      intc_req      = apb_req;
      pctr_req      = apb_req;
      gpio_req.psel = apb_req.psel && (bank == periph_map_pkg::bank_gpio);
      intc_req.psel = apb_req.psel && (bank == periph_map_pkg::bank_intc);
      pctr_req.psel = apb_req.psel && (bank == periph_map_pkg::bank_pctrs);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response merge

   // No device inserts wait states
   always_comb begin
      apb_rsp.pready  = access;
      apb_rsp.pslverr = 1'b0;
      case (bank)
         periph_map_pkg::bank_gpio: begin
            apb_rsp.prdata = gpio_rdata;
         end
         periph_map_pkg::bank_intc: begin
            apb_rsp.prdata = intc_rdata;
         end
         periph_map_pkg::bank_pctrs: begin
            apb_rsp.prdata = pctr_rdata;
         end
         default: begin
            apb_rsp.prdata  = '0;
            apb_rsp.pslverr = access;  // Hole in the map
         end
      endcase
   end

endmodule

/* apb_gpio.sv */
/* GPIO
 * 32-bit output register and a synchronized 32-bit input port
 */
`timescale 1ns/1ps

module apb_gpio (
   input  logic                        clk,
   input  logic                        arst_n,
   input  apb_pkg::apb_req_t           apb_req,
   output logic [apb_pkg::data_w-1:0]  rdata,
   input  logic [apb_pkg::data_w-1:0]  gpio_in,
   output logic [apb_pkg::data_w-1:0]  gpio_out
);

   logic [apb_pkg::data_w-1:0] in_meta;   // First sync stage
   logic [apb_pkg::data_w-1:0] in_sync;
   periph_map_pkg::ofs_t       ofs;
   logic                       wr_en;

   assign ofs   = apb_req.paddr[periph_map_pkg::bank_lsb-1:0];
   assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;

   // Output port, written on the completing edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         gpio_out <= periph_map_pkg::gpio_out_rst;
      end else if (wr_en && ofs == periph_map_pkg::gpio_out_ofs) begin
         gpio_out <= apb_req.pwdata;
      end
   end

   // Two-flop synchronizer
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         in_meta <= '0;
         in_sync <= '0;
      end else begin
         in_meta <= gpio_in;
         in_sync <= in_meta;
      end
   end

   // Writes to the input offset fall through here
   always_comb begin
      case (ofs)
         periph_map_pkg::gpio_out_ofs: rdata = gpio_out;
         periph_map_pkg::gpio_in_ofs:  rdata = in_sync;
         default:                      rdata = '0;
      endcase
   end

endmodule

/* apb_intc.sv */
/* Interrupt controller
 * Level sources pass straight through, edge sources latch until cleared
 */
`timescale 1ns/1ps

module apb_intc (
   input  logic                        clk,
   input  logic                        arst_n,
   input  apb_pkg::apb_req_t           apb_req,
   output logic [apb_pkg::data_w-1:0]  rdata,
   input  periph_map_pkg::irq_vec_t    irq_src,
   output logic                        irq
);

   periph_map_pkg::irq_vec_t src_q;     // Sampled sources
   periph_map_pkg::irq_vec_t pending;
   periph_map_pkg::irq_vec_t enable;

   // Edge sources only, bits nr_level and up
   logic [periph_map_pkg::nr_irqs-periph_map_pkg::nr_level-1:0] edge_prev;
   logic [periph_map_pkg::nr_irqs-periph_map_pkg::nr_level-1:0] edge_pend;
   logic [periph_map_pkg::nr_irqs-periph_map_pkg::nr_level-1:0] edge_rise;
   logic [periph_map_pkg::nr_irqs-periph_map_pkg::nr_level-1:0] edge_clr;

   periph_map_pkg::ofs_t ofs;
   logic                 wr_en;

   assign ofs   = apb_req.paddr[periph_map_pkg::bank_lsb-1:0];
   assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;

   ////////////////////////////////////////////////////////////////////////////
   // Source sampling and edge capture

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         src_q     <= '0;
         edge_prev <= '0;
      end else begin
         src_q     <= irq_src;
         edge_prev <= src_q[periph_map_pkg::nr_irqs-1:periph_map_pkg::nr_level];
      end
   end

   assign edge_rise = src_q[periph_map_pkg::nr_irqs-1:periph_map_pkg::nr_level] & ~edge_prev;

   // Clear mask from the write data, edge bits only
   always_comb begin
      edge_clr = '0;
      if (wr_en && ofs == periph_map_pkg::intc_clear_ofs) begin
         edge_clr = apb_req.pwdata[periph_map_pkg::nr_irqs-1:periph_map_pkg::nr_level];
      end
   end

   // A new edge wins over a clear in the same cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         edge_pend <= '0;
      end else begin
         edge_pend <= (edge_pend & ~edge_clr) | edge_rise;
      end
   end

   assign pending = {edge_pend, src_q[periph_map_pkg::nr_level-1:0]};

   ////////////////////////////////////////////////////////////////////////////
   // Enable mask and output

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         enable <= periph_map_pkg::intc_enable_rst;
      end else if (wr_en && ofs == periph_map_pkg::intc_enable_ofs) begin
         enable <= apb_req.pwdata[periph_map_pkg::nr_irqs-1:0];
      end
   end

   assign irq = |(pending & enable);

   always_comb begin
      rdata = '0;
      case (ofs)
         periph_map_pkg::intc_status_ofs: rdata[periph_map_pkg::nr_irqs-1:0] = pending;
         periph_map_pkg::intc_enable_ofs: rdata[periph_map_pkg::nr_irqs-1:0] = enable;
         default:                         rdata = '0;  // Clear reads as zero
      endcase
   end

endmodule

/* apb_pctrs.sv */
/* Cycle counter
 * Free-running 64-bit count with a high word captured on each low-word read
 */
`timescale 1ns/1ps

module apb_pctrs (
   input  logic                        clk,
   input  logic                        arst_n,
   input  apb_pkg::apb_req_t           apb_req,
   output logic [apb_pkg::data_w-1:0]  rdata
);

   logic [63:0]                count;
   logic [apb_pkg::data_w-1:0] hi_snap;  // Upper half at last low read
   logic                       enable;
   periph_map_pkg::ofs_t       ofs;
   logic                       wr_en;
   logic                       rd_en;

   assign ofs   = apb_req.paddr[periph_map_pkg::bank_lsb-1:0];
   assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;
   assign rd_en = apb_req.psel && apb_req.penable && !apb_req.pwrite;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count   <= '0;
         hi_snap <= '0;
         enable  <= 1'b0;
      end else begin
         if (wr_en && ofs == periph_map_pkg::pctr_lo_ofs) begin
            count <= '0;                     // Any write to low restarts
         end else if (enable) begin
            count <= count + 64'd1;
         end

         if (wr_en && ofs == periph_map_pkg::pctr_ctrl_ofs) begin
            enable <= apb_req.pwdata[0];
         end

         // Keeps a lo/hi read pair consistent
         if (rd_en && ofs == periph_map_pkg::pctr_lo_ofs) begin
            hi_snap <= count[63:32];
         end
      end
   end

   always_comb begin
      case (ofs)
         periph_map_pkg::pctr_lo_ofs:   rdata = count[31:0];
         periph_map_pkg::pctr_hi_ofs:   rdata = hi_snap;
         periph_map_pkg::pctr_ctrl_ofs: rdata = {31'b0, enable};
         default:                       rdata = '0;
      endcase
   end

endmodule

/* apb_pkg.sv */
/* APB bus definitions
 * Address and data widths, plus the packed request and response structs
 */
package apb_pkg;

   localparam int addr_w = 16;
   localparam int data_w = 32;

   // Requester to completer
   typedef struct packed {
      logic [addr_w-1:0] paddr;
      logic              psel;
      logic              penable;  // High in the access phase
      logic              pwrite;
      logic [data_w-1:0] pwdata;
   } apb_req_t;

   // Completer to requester
   typedef struct packed {
      logic [data_w-1:0] prdata;
      logic              pready;
      logic              pslverr;  // Unmapped bank
   } apb_rsp_t;

endpackage

/* periph_map_pkg.sv */
/* Peripheral address map
 * Bank numbers, register offsets, interrupt layout and reset values
 */
package periph_map_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Banks, 4 KB each

   localparam int bank_lsb   = 12;  // paddr[15:12] picks the bank
   localparam int nr_banks   = 16;

   localparam int bank_gpio  = 6;
   localparam int bank_intc  = 7;
   localparam int bank_pctrs = 12;

   ////////////////////////////////////////////////////////////////////////////
   // Register offsets within a bank

   typedef logic [bank_lsb-1:0] ofs_t;

   localparam ofs_t gpio_out_ofs    = 'h0;
   localparam ofs_t gpio_in_ofs     = 'h4;

   localparam ofs_t intc_status_ofs = 'h0;
   localparam ofs_t intc_enable_ofs = 'h4;
   localparam ofs_t intc_clear_ofs  = 'h8;  // Write 1 to clear

   localparam ofs_t pctr_lo_ofs     = 'h0;
   localparam ofs_t pctr_hi_ofs     = 'h4;  // Snapshot taken on low read
   localparam ofs_t pctr_ctrl_ofs   = 'h8;

   // Interrupt sources, level ones first then rising edge
   localparam int nr_irqs  = 6;
   localparam int nr_level = 4;

   typedef logic [nr_irqs-1:0] irq_vec_t;

   // Reset values
   localparam logic [31:0] gpio_out_rst    = 32'h0;
   localparam irq_vec_t    intc_enable_rst = '0;

endpackage

/* periph_subsys.f */
apb_pkg.sv
periph_map_pkg.sv
apb_bank_decode.sv
apb_gpio.sv
apb_intc.sv
apb_pctrs.sv
periph_top.sv
tb_periph_top.sv

/* periph_top.sv */
/* Peripheral subsystem top
 * APB bank decoder with GPIO, interrupt controller and cycle counter behind it
 */
`timescale 1ns/1ps

module periph_top (
   input  logic                        clk,
   input  logic                        arst_n,
   input  apb_pkg::apb_req_t           apb_req,
   output apb_pkg::apb_rsp_t           apb_rsp,
   input  logic [apb_pkg::data_w-1:0]  gpio_in,
   output logic [apb_pkg::data_w-1:0]  gpio_out,
   input  periph_map_pkg::irq_vec_t    irq_src,
   output logic                        irq
);

   apb_pkg::apb_req_t          gpio_req;
   apb_pkg::apb_req_t          intc_req;
   apb_pkg::apb_req_t          pctr_req;
   logic [apb_pkg::data_w-1:0] gpio_rdata;
   logic [apb_pkg::data_w-1:0] intc_rdata;
   logic [apb_pkg::data_w-1:0] pctr_rdata;

   apb_bank_decode decode0 (
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .gpio_req   (gpio_req),
      .intc_req   (intc_req),
      .pctr_req   (pctr_req),
      .gpio_rdata (gpio_rdata),
      .intc_rdata (intc_rdata),
      .pctr_rdata (pctr_rdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Devices

   apb_gpio gpio0 (              // Bank 6
      .clk      (clk),
      .arst_n   (arst_n),
      .apb_req  (gpio_req),
      .rdata    (gpio_rdata),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out)
   );

   apb_intc intc0 (              // Bank 7
      .clk     (clk),
      .arst_n  (arst_n),
      .apb_req (intc_req),
      .rdata   (intc_rdata),
      .irq_src (irq_src),
      .irq     (irq)
   );

   apb_pctrs pctrs0 (            // Bank 12
      .clk     (clk),
      .arst_n  (arst_n),
      .apb_req (pctr_req),
      .rdata   (pctr_rdata)
   );

endmodule

/* tb_periph_top.sv */
/* Peripheral subsystem testbench
 * Random APB traffic against a register model of GPIO, interrupts and counter
 */
`timescale 1ns/1ps

module tb_periph_top;

   localparam int len_reset = 16;   // Iterations per test
   localparam int len_gpio  = 12;
   localparam int len_level = 12;
   localparam int len_edge  = 8;
   localparam int len_cnt   = 8;
   localparam int len_dis   = 6;
   localparam int timeout_cycles =
      (len_reset + len_gpio + len_level + len_edge + len_cnt + len_dis + 1) * 40;

   logic                     clk;
   logic                     arst_n;
   apb_pkg::apb_req_t        apb_req;
   apb_pkg::apb_rsp_t        apb_rsp;
   logic [31:0]              gpio_in;
   logic [31:0]              gpio_out;
   periph_map_pkg::irq_vec_t irq_src;
   logic                     irq;

   int unsigned cyc = 0;    // Rising edges since time zero
   int unsigned rd_cyc;     // Cycle of the last sampled access phase
   int          checks = 0;
   int          errors = 0;

   periph_top dut0 (
      .clk (clk), .arst_n (arst_n), .apb_req (apb_req), .apb_rsp (apb_rsp),
      .gpio_in (gpio_in), .gpio_out (gpio_out), .irq_src (irq_src), .irq (irq)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   initial begin
      repeat (timeout_cycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Errors found");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus access and checking

   function automatic logic [15:0] reg_addr(input int bank, input periph_map_pkg::ofs_t ofs);
      return {bank[3:0], ofs};
   endfunction

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                       input logic exp_err, output logic [31:0] rdata);
      @(posedge clk);                   // Setup phase
      apb_req.paddr   <= addr;
      apb_req.pwrite  <= wr;
      apb_req.pwdata  <= wdata;
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      @(negedge clk);
      check_eq("pready in setup", apb_rsp.pready, 1'b0);
      check_eq("pslverr in setup", apb_rsp.pslverr, 1'b0);
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);                   // Access phase, outputs settled
      check_eq("pready", apb_rsp.pready, 1'b1);
      check_eq("pslverr", apb_rsp.pslverr, exp_err);
      rdata  = apb_rsp.prdata;
      rd_cyc = cyc;
      @(posedge clk);                   // Completing edge
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic write_reg(input int bank, input periph_map_pkg::ofs_t ofs,
                            input logic [31:0] data);
      logic [31:0] discard;
      xfer(1'b1, reg_addr(bank, ofs), data, 1'b0, discard);
   endtask

   task automatic read_reg(input int bank, input periph_map_pkg::ofs_t ofs,
                           output logic [31:0] data);
      xfer(1'b0, reg_addr(bank, ofs), 32'h0, 1'b0, data);
   endtask

   task automatic expect_reg(input string what, input int bank, input periph_map_pkg::ofs_t ofs,
                             input logic [31:0] exp);
      logic [31:0] got;
      read_reg(bank, ofs, got);
      check_eq(what, got, exp);
   endtask

   task automatic end_test(input int num, input string name, input int mark);
      $display("test %0d %s: %0d errors", num, name, errors - mark);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus

   initial begin
      logic [31:0]              v, a, b, w, gin, gpio_model;
      logic [3:0]               lvl;
      periph_map_pkg::irq_vec_t en_model, pend_model;
      periph_map_pkg::ofs_t     ofs;
      int unsigned              ca;
      int                       e, k, mark;
      logic                     err;

      v       = $urandom(32'h777ea6e5);
      arst_n  = 1'b0;
      apb_req = '0;
      gpio_in = '0;
      irq_src = '0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;

      // Reset values and decode of every bank
      mark = errors;
      @(negedge clk);
      check_eq("gpio_out after reset", gpio_out, 32'h0);
      check_eq("irq after reset", irq, 1'b0);
      for (int bank = 0; bank < len_reset; bank++) begin
         ofs = periph_map_pkg::ofs_t'($urandom_range(0, 1023) * 4);
         err = !(bank == periph_map_pkg::bank_gpio || bank == periph_map_pkg::bank_intc ||
                 bank == periph_map_pkg::bank_pctrs);
         xfer(1'b0, reg_addr(bank, ofs), 32'h0, err, v);
         check_eq("read data after reset", v, 32'h0);
      end
      end_test(1, "reset_decode", mark);

      mark = errors;
      for (int i = 0; i < len_gpio; i++) begin
         gpio_model = $urandom;
         write_reg(periph_map_pkg::bank_gpio, periph_map_pkg::gpio_out_ofs, gpio_model);
         @(negedge clk);
         check_eq("gpio_out", gpio_out, gpio_model);
         expect_reg("gpio out readback", periph_map_pkg::bank_gpio,
                    periph_map_pkg::gpio_out_ofs, gpio_model);
         gin = $urandom;
         @(posedge clk);
         gpio_in <= gin;
         repeat (3) @(posedge clk);     // Through the synchronizer
         expect_reg("gpio in", periph_map_pkg::bank_gpio, periph_map_pkg::gpio_in_ofs, gin);
         write_reg(periph_map_pkg::bank_gpio, periph_map_pkg::gpio_in_ofs, $urandom);
         @(negedge clk);
         check_eq("gpio_out after input write", gpio_out, gpio_model);
         expect_reg("gpio in after write", periph_map_pkg::bank_gpio,
                    periph_map_pkg::gpio_in_ofs, gin);
      end
      end_test(2, "gpio", mark);

      mark = errors;
      for (int i = 0; i < len_level; i++) begin
         en_model = $urandom;
         write_reg(periph_map_pkg::bank_intc, periph_map_pkg::intc_enable_ofs, 32'(en_model));
         lvl = $urandom;
         pend_model = periph_map_pkg::irq_vec_t'(lvl);
         @(posedge clk);
         irq_src <= pend_model;
         repeat (3) @(posedge clk);
         @(negedge clk);
         check_eq("irq from level sources", irq, |(pend_model & en_model));
         expect_reg("intc status", periph_map_pkg::bank_intc, periph_map_pkg::intc_status_ofs,
                    32'(pend_model));
         expect_reg("intc enable", periph_map_pkg::bank_intc, periph_map_pkg::intc_enable_ofs,
                    32'(en_model));
      end
      end_test(3, "irq_level", mark);

      // Edge pulses latch, clear drops only edge bits
      mark = errors;
      for (int i = 0; i < len_edge; i++) begin
         en_model = $urandom;
         write_reg(periph_map_pkg::bank_intc, periph_map_pkg::intc_enable_ofs, 32'(en_model));
         lvl = $urandom;
         e   = $urandom_range(periph_map_pkg::nr_level, periph_map_pkg::nr_irqs - 1);
         pend_model = periph_map_pkg::irq_vec_t'(lvl) | (periph_map_pkg::irq_vec_t'(1) << e);
         @(posedge clk);
         irq_src <= pend_model;
         @(posedge clk);
         irq_src <= periph_map_pkg::irq_vec_t'(lvl);
         repeat (3) @(posedge clk);
         @(negedge clk);
         check_eq("irq with edge pending", irq, |(pend_model & en_model));
         expect_reg("status with edge", periph_map_pkg::bank_intc,
                    periph_map_pkg::intc_status_ofs, 32'(pend_model));
         write_reg(periph_map_pkg::bank_intc, periph_map_pkg::intc_clear_ofs, 32'h3f);
         pend_model = periph_map_pkg::irq_vec_t'(lvl);
         @(negedge clk);
         check_eq("irq after clear", irq, |(pend_model & en_model));
         expect_reg("status after clear", periph_map_pkg::bank_intc,
                    periph_map_pkg::intc_status_ofs, 32'(pend_model));
      end
      end_test(4, "irq_edge", mark);

      mark = errors;
      write_reg(periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_ctrl_ofs, 32'h1);
      for (int i = 0; i < len_cnt; i++) begin
         write_reg(periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_lo_ofs, $urandom);
         read_reg(periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_lo_ofs, v);
         check_eq("count shortly after restart below 4", 32'(v < 32'd4), 32'h1);
         read_reg(periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_lo_ofs, a);
         ca = rd_cyc;
         k  = $urandom_range(0, 12);
         repeat (k) @(posedge clk);
         read_reg(periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_lo_ofs, b);
         check_eq("count delta", b - a, rd_cyc - ca);
         expect_reg("high snapshot", periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_hi_ofs,
                    32'h0);
      end
      end_test(5, "counter_run", mark);

      mark = errors;
      for (int i = 0; i < len_dis; i++) begin
         w = $urandom;
         write_reg(periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_ctrl_ofs, w);
         expect_reg("ctrl readback", periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_ctrl_ofs,
                    32'(w[0]));
         write_reg(periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_ctrl_ofs, w & ~32'h1);
         expect_reg("ctrl disabled", periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_ctrl_ofs,
                    32'h0);
         read_reg(periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_lo_ofs, a);
         k = $urandom_range(0, 12);
         repeat (k) @(posedge clk);
         read_reg(periph_map_pkg::bank_pctrs, periph_map_pkg::pctr_lo_ofs, b);
         check_eq("stopped count", b, a);
      end
      end_test(6, "counter_stop", mark);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule
